/* sim.f */
+incdir+hw
hw/ntp_ts_pkg.sv
hw/ntp_ts_ifs.sv
hw/ntp_api_regs.sv
hw/ntp_stamp_capture.sv
hw/ntp_header_tx.sv
hw/ntp_timestamp_top.sv
test/tb_ntp_timestamp.sv

/* run_sim.sh */
#!/bin/sh
# Builds the testbench with Verilator, runs it and checks the log.
# Returns a nonzero status on any failure.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing -f sim.f --top-module tb_ntp_timestamp -Mdir obj_dir -o sim_tb
if [ $? -ne 0 ]; then
  echo "Verilator build failed"
  exit 1
fi

./obj_dir/sim_tb > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if grep -q "^Done: no errors$" sim.log; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi

/* test/ntp_timestamp_tests.txt */
# op W: addr data | R: addr expected | T, C: kod rec ver poll time origin extra
# time or origin 0 takes LFSR bits; T extra 1 adds a request while busy; C extra is last block before clear
W 11 00010203
W 12 00000a0b
W 13 47505300
W 14 00008000
R 11 00010203
R 12 00000a0b
R 13 47505300
R 14 00008000
R 10 00000000
W 20 deadbeef
R 20 00000000
T 0 0 4 06 e8c3a1b2fffff000 0 0
W 10 dc020aec
R 10 dc020aec
T 0 0 2 04 0 0 0
T 1 0 4 06 0 0 0
W 10 00000000
T 0 1 3 0a 0 5a5a5a5a5a5a5a5a 1
C 0 1 4 06 0 0 2
T 0 0 4 06 0 0 0

/* test/tb_ntp_timestamp.sv */
// Run from the project root so the test data path resolves; at most 64 test lines are read
`timescale 1ns/1ps
`include "ntp_ts_cfg.svh"

module tb_ntp_timestamp;

  // ------------------------------
  // DUT signals
  // ------------------------------
  logic        i_clk;
  logic        i_areset;
  logic [63:0] i_ntp_time;
  logic        o_busy;
  logic        i_parser_clear;
  logic        i_parser_record_receive_timestamp;
  logic        i_parser_transmit;
  logic [63:0] i_parser_origin_timestamp;
  logic [2:0]  i_parser_version_number;
  logic [7:0]  i_parser_poll;
  logic        i_parser_kiss_of_death;
  logic        o_tx_wr_en;
  logic [2:0]  o_tx_ntp_header_block;
  logic [63:0] o_tx_ntp_header_data;
  logic        i_api_cs;
  logic        i_api_we;
  logic [7:0]  i_api_address;
  logic [31:0] i_api_write_data;
  logic [31:0] o_api_read_data;

  ntp_timestamp_top dut (.*);

  // Reference model state
  logic [31:0] m_config;
  logic [31:0] m_root_delay;
  logic [31:0] m_root_disp;
  logic [31:0] m_ref_id;
  logic [31:0] m_tx_ofs;
  logic [63:0] m_receive;      // Last recorded arrival time
  logic [63:0] exp_blk [0:5];

  logic [7:0]  op_tab  [0:63]; // One letter per test
  logic [63:0] arg_tab [0:63][0:6];
  logic [15:0] lfsr;
  int          n_tests;
  int          errors;
  int          failed_tests;
  int          errs_before;
  int          cycles;
  int          cycle_limit;

  initial i_clk = 1'b0;
  always #20 i_clk = ~i_clk; // 40 ns period

  // Run limit, armed once the test count is known
  always @(posedge i_clk) begin
    cycles <= cycles + 1;
    if (cycle_limit > 0 && cycles >= cycle_limit) begin
      $display("Timeout after %0d cycles, the DUT stopped responding", cycles);
      $display("Done: errors found");
      $finish;
    end
  end

  // ------------------------------
  // Helpers
  // ------------------------------
  function automatic logic [15:0] lfsr_next(input logic [15:0] s);
    return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]}; // x^16 + x^14 + x^13 + x^11
  endfunction

  task automatic take_bits(input int n, output logic [63:0] v);
    v = 64'h0;
    for (int b = 0; b < n; b++) begin
      v    = {v[62:0], lfsr[15]}; // One step per bit
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic check(input string name, input logic [63:0] expv, input logic [63:0] got);
    if (got !== expv) begin
      $display("[ERROR] %s expected 0x%h got 0x%h", name, expv, got);
      errors++;
    end
  endtask

  task automatic load_tests();
    int               fd;
    int               cnt;
    logic [7:0]       op;
    logic [8*128-1:0] rest;
    n_tests = 0;
    fd = $fopen("test/ntp_timestamp_tests.txt", "r");
    if (fd != 0) begin
      while (n_tests < 64) begin
        cnt = $fscanf(fd, "%s", op);
        if (cnt != 1)
          break;
        if (op == "#") begin
          cnt = $fgets(rest, fd);     // Column notes
        end else begin
          op_tab[n_tests] = op;
          if (op == "W" || op == "R")
            cnt = $fscanf(fd, "%h %h", arg_tab[n_tests][0], arg_tab[n_tests][1]);
          else
            cnt = $fscanf(fd, "%h %h %h %h %h %h %h", arg_tab[n_tests][0],
                          arg_tab[n_tests][1], arg_tab[n_tests][2], arg_tab[n_tests][3],
                          arg_tab[n_tests][4], arg_tab[n_tests][5], arg_tab[n_tests][6]);
          n_tests++;
        end
      end
      $fclose(fd);
    end
  endtask

  // ------------------------------
  // API bus
  // ------------------------------
  task automatic api_write(input logic [63:0] addr, input logic [63:0] data);
    @(posedge i_clk);
    i_api_cs         <= 1'b1;
    i_api_we         <= 1'b1;
    i_api_address    <= addr[7:0];
    i_api_write_data <= data[31:0];
    @(posedge i_clk);                  // Write lands here
    i_api_cs <= 1'b0;
    i_api_we <= 1'b0;
    case (addr[7:0])
      `NTP_TS_ADDR_CONFIG:     m_config     = data[31:0];
      `NTP_TS_ADDR_ROOT_DELAY: m_root_delay = data[31:0];
      `NTP_TS_ADDR_ROOT_DISP:  m_root_disp  = data[31:0];
      `NTP_TS_ADDR_REF_ID:     m_ref_id     = data[31:0];
      `NTP_TS_ADDR_TX_OFS:     m_tx_ofs     = data[31:0];
      default: ;                       // Unmapped address has no register
    endcase
  endtask

  task automatic api_read(input logic [63:0] addr, input logic [63:0] expv);
    @(posedge i_clk);
    i_api_cs      <= 1'b1;
    i_api_we      <= 1'b0;
    i_api_address <= addr[7:0];
    @(negedge i_clk);                  // Combinational read has settled
    check("o_api_read_data", {32'h0, expv[31:0]}, {32'h0, o_api_read_data});
    @(posedge i_clk);
    i_api_cs <= 1'b0;
  endtask

  // Expected header from the field rules
  task automatic build_expected(input logic kod, input logic [2:0] ver, input logic [7:0] poll,
                                input logic [63:0] t, input logic [63:0] origin);
    logic [2:0]  vn;
    logic [2:0]  mode;
    logic [7:0]  stratum;
    logic [7:0]  pl;
    logic [31:0] refid;
    vn   = (m_config[29:27] != 3'd0) ? m_config[29:27] : ver;
    mode = (m_config[26:24] != 3'd0) ? m_config[26:24] : 3'd4; // Server
    if (kod)
      stratum = 8'd0;
    else if (m_config[23:16] != 8'd0)
      stratum = m_config[23:16];
    else
      stratum = 8'd1;
    pl    = (m_config[15:8] != 8'd0) ? m_config[15:8] : poll;
    refid = kod ? "NTSN" : m_ref_id;
    exp_blk[0] = {m_config[31:30], vn, mode, stratum, pl, m_config[7:0], m_root_delay};
    exp_blk[1] = {m_root_disp, refid};
    exp_blk[2] = {t[63:32] - 32'd1, 32'h0}; // Previous second with zero fraction
    exp_blk[3] = origin;
    exp_blk[4] = m_receive;
    exp_blk[5] = t + {32'h0, m_tx_ofs};
  endtask

  // ------------------------------
  // Transmit and clear tests
  // ------------------------------
  task automatic header_test(input int idx, input bit is_clear);
    logic [63:0] t;
    logic [63:0] origin;
    int          extra;
    int          nblk;
    int          exp_count;
    bit          done;
    t      = arg_tab[idx][4];
    origin = arg_tab[idx][5];
    extra  = int'(arg_tab[idx][6][31:0]);
    if (t == 64'h0)
      take_bits(64, t);
    if (origin == 64'h0)
      take_bits(64, origin);
    if (arg_tab[idx][1][0])
      m_receive = t;                   // Recorded on the accepting edge
    build_expected(arg_tab[idx][0][0], arg_tab[idx][2][2:0], arg_tab[idx][3][7:0], t, origin);
    exp_count = is_clear ? extra + 2 : 6;

    @(posedge i_clk);
    i_parser_transmit                 <= 1'b1;
    i_parser_record_receive_timestamp <= arg_tab[idx][1][0];
    i_parser_kiss_of_death            <= arg_tab[idx][0][0]; // Held through the header
    i_parser_version_number           <= arg_tab[idx][2][2:0];
    i_parser_poll                     <= arg_tab[idx][3][7:0];
    i_parser_origin_timestamp         <= origin;
    i_ntp_time                        <= t;
    @(posedge i_clk);                  // Accepting edge
    i_parser_transmit                 <= 1'b0;
    i_parser_record_receive_timestamp <= 1'b0;
    i_ntp_time                        <= t + 64'h1_0000_0000;

    nblk = 0;
    done = 1'b0;
    while (!done) begin
      @(negedge i_clk);
      if (o_tx_wr_en) begin
        check("o_tx_ntp_header_block", 64'(nblk), 64'(o_tx_ntp_header_block));
        check("o_tx_ntp_header_data", (nblk < 6) ? exp_blk[nblk] : 64'h0,
              o_tx_ntp_header_data);
        check("o_busy", 64'h1, 64'(o_busy));
        nblk++;
      end else begin
        done = 1'b1;                   // Header ended or never started after the accept
      end
      if (!done) begin
        @(posedge i_clk);
        i_ntp_time <= i_ntp_time + 64'h100;
        // Busy request and record that must be ignored
        i_parser_transmit                 <= (!is_clear && extra != 0 && nblk == 2);
        i_parser_record_receive_timestamp <= (!is_clear && extra != 0 && nblk == 2);
        i_parser_clear                    <= (is_clear && nblk == extra + 1);
      end
    end
    check("o_busy", 64'h0, 64'(o_busy));
    check("write cycles", 64'(exp_count), 64'(nblk));
  endtask

  // ------------------------------
  // Main sequence
  // ------------------------------
  initial begin
    i_areset                          = 1'b1;
    i_ntp_time                        = 64'h0;
    i_parser_clear                    = 1'b0;
    i_parser_record_receive_timestamp = 1'b0;
    i_parser_transmit                 = 1'b0;
    i_parser_origin_timestamp         = 64'h0;
    i_parser_version_number           = 3'd0;
    i_parser_poll                     = 8'd0;
    i_parser_kiss_of_death            = 1'b0;
    i_api_cs                          = 1'b0;
    i_api_we                          = 1'b0;
    i_api_address                     = 8'h0;
    i_api_write_data                  = 32'h0;
    m_config     = 32'h0;
    m_root_delay = 32'h0;
    m_root_disp  = 32'h0;
    m_ref_id     = 32'h0;
    m_tx_ofs     = 32'h0;
    m_receive    = 64'h0;
    lfsr         = 16'd64261;
    errors       = 0;
    failed_tests = 0;
    cycles       = 0;
    cycle_limit  = 0;
    load_tests();
    if (n_tests <= 0) begin
      $display("No test lines could be read from test/ntp_timestamp_tests.txt");
      $display("Done: errors found");
      $finish;
    end else begin
      cycle_limit = n_tests * 20;
      repeat (3) @(posedge i_clk);
      i_areset <= 1'b0;
      @(negedge i_clk);
      check("o_busy", 64'h0, 64'(o_busy)); // Idle out of reset
      check("o_tx_wr_en", 64'h0, 64'(o_tx_wr_en));
      for (int i = 0; i < n_tests; i++) begin
        errs_before = errors;
        case (op_tab[i])
          "W": api_write(arg_tab[i][0], arg_tab[i][1]);
          "R": api_read(arg_tab[i][0], arg_tab[i][1]);
          "T": header_test(i, 1'b0);
          "C": header_test(i, 1'b1);
          default: begin
            $display("Test %0d has an unknown operation", i);
            errors++;
          end
        endcase
        if (errors == errs_before) begin
          $display("Test %0d (%s) ok", i, op_tab[i]);
        end else begin
          $display("Test %0d (%s) failed", i, op_tab[i]);
          failed_tests++;
        end
      end
      $display("%0d tests, %0d failed, %0d errors", n_tests, failed_tests, errors);
      if (errors == 0) begin
        $display("Done: no errors");
      end else begin
        $display("Done: errors found");
      end
      $finish;
    end
  end

endmodule

/* hw/ntp_timestamp_top.sv */
// Sink must take one header block per cycle while o_tx_wr_en is high; no core ID registers
`timescale 1ns/1ps
`include "ntp_ts_cfg.svh"

module ntp_timestamp_top
  import ntp_ts_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_areset,                          // Async, active high

  input  ntp_time_t                 i_ntp_time,
  output logic                      o_busy,                            // To the parser

  // ------------------------------
  // Parser side
  // ------------------------------
  input  logic                      i_parser_clear,                    // Drop current packet
  input  logic                      i_parser_record_receive_timestamp,
  input  logic                      i_parser_transmit,
  input  ntp_time_t                 i_parser_origin_timestamp,
  input  ntp_version_t              i_parser_version_number,
  input  ntp_poll_t                 i_parser_poll,
  input  logic                      i_parser_kiss_of_death,

  // Header out
  output logic                      o_tx_wr_en,
  output ntp_blk_idx_t              o_tx_ntp_header_block,
  output logic [`NTP_TS_BLK_W-1:0]  o_tx_ntp_header_data,

  // ------------------------------
  // API bus
  // ------------------------------
  input  logic                      i_api_cs,
  input  logic                      i_api_we,
  input  logic [`NTP_TS_API_AW-1:0] i_api_address,
  input  logic [`NTP_TS_API_DW-1:0] i_api_write_data,
  output logic [`NTP_TS_API_DW-1:0] o_api_read_data
);

  ntp_cfg_if   cfg_bus ();
  ntp_stamp_if stamp_bus ();

  logic accept;   // Idle and transmit requested
  logic busy;

  ntp_api_regs u_regs (
    .i_clk            (i_clk),
    .i_areset         (i_areset),
    .i_api_cs         (i_api_cs),
    .i_api_we         (i_api_we),
    .i_api_address    (i_api_address),
    .i_api_write_data (i_api_write_data),
    .o_api_read_data  (o_api_read_data),
    .cfg              (cfg_bus.regs)
  );

  ntp_stamp_capture u_capture (
    .i_clk       (i_clk),
    .i_areset    (i_areset),
    .i_ntp_time  (i_ntp_time),
    .i_accept    (accept),
    .i_busy      (busy),
    .i_record_rx (i_parser_record_receive_timestamp),
    .i_origin_ts (i_parser_origin_timestamp),
    .i_version   (i_parser_version_number),
    .i_poll      (i_parser_poll),
    .cfg         (cfg_bus.stamp),
    .st          (stamp_bus.cap)
  );

  ntp_header_tx u_tx (
    .i_clk           (i_clk),
    .i_areset        (i_areset),
    .i_transmit      (i_parser_transmit),
    .i_clear         (i_parser_clear),
    .i_kiss_of_death (i_parser_kiss_of_death),
    .cfg             (cfg_bus.hdr),
    .st              (stamp_bus.hdr),
    .o_accept        (accept),
    .o_busy          (busy),
    .o_tx_wr_en      (o_tx_wr_en),
    .o_tx_block      (o_tx_ntp_header_block),
    .o_tx_data       (o_tx_ntp_header_data)
  );

  assign o_busy = busy;

endmodule

/* hw/ntp_header_tx.sv */
// One block per cycle with no back-pressure; block data follows the live kiss-of-death input
`timescale 1ns/1ps
`include "ntp_ts_cfg.svh"

module ntp_header_tx
  import ntp_ts_pkg::*;
(
  input  logic                     i_clk,
  input  logic                     i_areset,
  input  logic                     i_transmit,      // Parser says packet OK
  input  logic                     i_clear,         // Abort current header
  input  logic                     i_kiss_of_death,
  ntp_cfg_if.hdr                   cfg,
  ntp_stamp_if.hdr                 st,
  output logic                     o_accept,        // Request taken this edge
  output logic                     o_busy,
  output logic                     o_tx_wr_en,
  output ntp_blk_idx_t             o_tx_block,
  output logic [`NTP_TS_BLK_W-1:0] o_tx_data
);

  // ------------------------------
  // State and block counter
  // ------------------------------
  tx_state_e    state_q;
  tx_state_e    state_d;
  ntp_blk_idx_t blk_q;
  ntp_blk_idx_t blk_d;
  logic         last_blk;

  assign last_blk = (blk_q == ntp_blk_idx_t'(`NTP_TS_BLOCKS - 1));
  assign o_accept = (state_q == TX_IDLE) && i_transmit;

  always_comb begin
    state_d = state_q;
    blk_d   = '0;                      // Counter parks at 0 outside a write
    if (i_clear) begin
      state_d = TX_IDLE;               // Clear wins over everything
    end else begin
      case (state_q)
        TX_IDLE: begin
          if (i_transmit)
            state_d = TX_WRITE;
        end
        TX_WRITE: begin
          if (last_blk) begin
            state_d = TX_IDLE;         // Block 5 was the last
          end else begin
            blk_d = blk_q + ntp_blk_idx_t'(1);
          end
        end
        default: state_d = TX_IDLE;
      endcase
    end
  end

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      state_q <= TX_IDLE;
      blk_q   <= '0;
    end else begin
      state_q <= state_d;
      blk_q   <= blk_d;
    end
  end

  assign o_busy     = (state_q != TX_IDLE);
  assign o_tx_wr_en = (state_q == TX_WRITE);
  assign o_tx_block = blk_q;

  // ------------------------------
  // Header field rules
  // ------------------------------
  logic [1:0]   f_li;
  ntp_version_t f_vn;
  logic [2:0]   f_mode;
  logic [7:0]   f_stratum;
  ntp_poll_t    f_poll;
  logic [7:0]   f_precision;
  ntp_word_t    f_ref_id;

  assign f_li        = cfg.config_word[31:30];                       // Passed through as set
  assign f_vn        = (cfg.config_word[29:27] != '0) ? cfg.config_word[29:27]
                                                      : st.client_version;
  assign f_mode      = (cfg.config_word[26:24] != '0) ? cfg.config_word[26:24]
                                                      : `NTP_TS_DEF_MODE;
  assign f_stratum   = i_kiss_of_death                 ? 8'd0        // KoD
                     : (cfg.config_word[23:16] != '0) ? cfg.config_word[23:16]
                                                      : `NTP_TS_DEF_STRATUM;
  assign f_poll      = (cfg.config_word[15:8] != '0)  ? cfg.config_word[15:8]
                                                      : st.client_poll;
  assign f_precision = cfg.config_word[7:0];
  assign f_ref_id    = i_kiss_of_death ? `NTP_TS_KOD_REFID : cfg.ref_id;

  // ------------------------------
  // Packet and block mux
  // ------------------------------
  logic [`NTP_TS_HDR_BITS-1:0] packet;
  logic [`NTP_TS_HDR_BITS-1:0] packet_sh;

  // RFC 5905 figure 8 order, MSB first
  assign packet = {f_li, f_vn, f_mode, f_stratum, f_poll, f_precision,
                   cfg.root_delay,
                   cfg.root_disp,
                   f_ref_id,
                   st.ref_seconds, ntp_word_t'(0),                   // Zero fraction
                   st.origin_ts,
                   st.receive_ts,
                   st.transmit_ts};

  // Shift wanted block to the top; indices past 5 shift in zeros
  assign packet_sh = packet << (blk_q * `NTP_TS_BLK_W);
  assign o_tx_data = packet_sh[`NTP_TS_HDR_BITS-1 -: `NTP_TS_BLK_W];

endmodule

/* hw/ntp_stamp_capture.sv */
// Captures on the accepting edge; receive stamp only while the transmitter is idle
`timescale 1ns/1ps
`include "ntp_ts_cfg.svh"

module ntp_stamp_capture
  import ntp_ts_pkg::*;
(
  input  logic         i_clk,
  input  logic         i_areset,
  input  ntp_time_t    i_ntp_time,   // Free-running NTP clock
  input  logic         i_accept,     // Request taken this edge
  input  logic         i_busy,       // Header in flight
  input  logic         i_record_rx,  // Parser asks for an arrival stamp
  input  ntp_time_t    i_origin_ts,
  input  ntp_version_t i_version,
  input  ntp_poll_t    i_poll,
  ntp_cfg_if.stamp     cfg,
  ntp_stamp_if.cap     st
);

  ntp_time_t    origin_q;
  ntp_time_t    receive_q;
  ntp_time_t    transmit_q;
  ntp_word_t    ref_sec_q;
  ntp_version_t version_q;
  ntp_poll_t    poll_q;

  // ------------------------------
  // Derived timestamps
  // ------------------------------
  ntp_time_t transmit_d;
  ntp_word_t ref_sec_d;

  // Offset only touches the fraction and carries upward
  assign transmit_d = i_ntp_time + {{(`NTP_TS_TIME_W - `NTP_TS_API_DW){1'b0}}, cfg.tx_ofs};
  // Assume reference was set at the previous PPS
  assign ref_sec_d  = i_ntp_time[`NTP_TS_TIME_W-1 -: `NTP_TS_API_DW] - ntp_word_t'(1);

  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      origin_q   <= '0;
      receive_q  <= '0;
      transmit_q <= '0;
      ref_sec_q  <= '0;
      version_q  <= '0;
      poll_q     <= '0;
    end else begin
      if (i_accept) begin
        origin_q   <= i_origin_ts; // Echo client transmit time
        transmit_q <= transmit_d;
        ref_sec_q  <= ref_sec_d;
        version_q  <= i_version;
        poll_q     <= i_poll;
      end
      if (i_record_rx && !i_busy)
        receive_q <= i_ntp_time;   // Arrival of the request
    end
  end

  assign st.origin_ts      = origin_q;
  assign st.receive_ts     = receive_q;
  assign st.transmit_ts    = transmit_q;
  assign st.ref_seconds    = ref_sec_q;
  assign st.client_version = version_q;
  assign st.client_poll    = poll_q;

endmodule

/* hw/ntp_api_regs.sv */
// Writes take effect next cycle, reads are combinational; unmapped addresses read as zero
`timescale 1ns/1ps
`include "ntp_ts_cfg.svh"

module ntp_api_regs
  import ntp_ts_pkg::*;
(
  input  logic                      i_clk,
  input  logic                      i_areset,         // Async, active high
  input  logic                      i_api_cs,
  input  logic                      i_api_we,
  input  logic [`NTP_TS_API_AW-1:0] i_api_address,
  input  logic [`NTP_TS_API_DW-1:0] i_api_write_data,
  output logic [`NTP_TS_API_DW-1:0] o_api_read_data,
  ntp_cfg_if.regs                   cfg
);

  // ------------------------------
  // Register storage
  // ------------------------------
  ntp_word_t config_q;     // Header config word
  ntp_word_t root_delay_q;
  ntp_word_t root_disp_q;
  ntp_word_t ref_id_q;
  ntp_word_t tx_ofs_q;

  logic wr_en;
  logic rd_en;

  assign wr_en = i_api_cs & i_api_we;
  assign rd_en = i_api_cs & ~i_api_we;

  // Write decode, one register per address
  always_ff @(posedge i_clk or posedge i_areset) begin
    if (i_areset) begin
      config_q     <= '0;
      root_delay_q <= '0;
      root_disp_q  <= '0;
      ref_id_q     <= '0;
      tx_ofs_q     <= '0;
    end else if (wr_en) begin
      case (i_api_address)
        REG_CONFIG:     config_q     <= i_api_write_data;
        REG_ROOT_DELAY: root_delay_q <= i_api_write_data;
        REG_ROOT_DISP:  root_disp_q  <= i_api_write_data;
        REG_REF_ID:     ref_id_q     <= i_api_write_data;
        REG_TX_OFS:     tx_ofs_q     <= i_api_write_data;
        default: ;                   // Unmapped, dropped
      endcase
    end
  end

  // Read mux, zero outside a read
  always_comb begin
    o_api_read_data = '0;
    if (rd_en) begin
      case (i_api_address)
        REG_CONFIG:     o_api_read_data = config_q;
        REG_ROOT_DELAY: o_api_read_data = root_delay_q;
        REG_ROOT_DISP:  o_api_read_data = root_disp_q;
        REG_REF_ID:     o_api_read_data = ref_id_q;
        REG_TX_OFS:     o_api_read_data = tx_ofs_q;
        default:        o_api_read_data = '0;
      endcase
    end
  end

  // Out to the rest of the core
  assign cfg.config_word = config_q;
  assign cfg.root_delay  = root_delay_q;
  assign cfg.root_disp   = root_disp_q;
  assign cfg.ref_id      = ref_id_q;
  assign cfg.tx_ofs      = tx_ofs_q;

endmodule

/* hw/ntp_ts_ifs.sv */
// Internal bundles only; all signals are level-valued and sampled on the core clock
`timescale 1ns/1ps
`include "ntp_ts_cfg.svh"

// ------------------------------
// Server configuration bundle
// ------------------------------
interface ntp_cfg_if
  import ntp_ts_pkg::*;
();
  ntp_word_t config_word; // LI | VN | mode | stratum | poll | precision
  ntp_word_t root_delay;
  ntp_word_t root_disp;
  ntp_word_t ref_id;
  ntp_word_t tx_ofs;      // Transmit timestamp offset

  // Register bank drives everything
  modport regs (
    output config_word, root_delay, root_disp, ref_id, tx_ofs
  );

  // Capture only needs the offset
  modport stamp (
    input tx_ofs
  );

  // Header composer, header fields only
  modport hdr (
    input config_word, root_delay, root_disp, ref_id
  );
endinterface

// ------------------------------
// Captured per-request values
// ------------------------------
interface ntp_stamp_if
  import ntp_ts_pkg::*;
();
  ntp_time_t    origin_ts;      // Client transmit time echoed back
  ntp_time_t    receive_ts;     // Time of request arrival
  ntp_time_t    transmit_ts;    // Now plus offset
  ntp_word_t    ref_seconds;    // Seconds of last PPS
  ntp_version_t client_version;
  ntp_poll_t    client_poll;

  modport cap (
    output origin_ts, receive_ts, transmit_ts, ref_seconds, client_version, client_poll
  );

  modport hdr (
    input origin_ts, receive_ts, transmit_ts, ref_seconds, client_version, client_poll
  );
endinterface

/* hw/ntp_ts_pkg.sv */
// Types for the NTP header stage; widths follow the configuration header and are not tunable
`include "ntp_ts_cfg.svh"

package ntp_ts_pkg;

  // ------------------------------
  // Transmitter states
  // ------------------------------
  typedef enum logic {
    TX_IDLE  = 1'b0, // Waiting for a transmit request
    TX_WRITE = 1'b1  // Streaming header blocks
  } tx_state_e;

  // ------------------------------
  // API register addresses
  // ------------------------------
  typedef enum logic [`NTP_TS_API_AW-1:0] {
    REG_CONFIG     = `NTP_TS_ADDR_CONFIG,
    REG_ROOT_DELAY = `NTP_TS_ADDR_ROOT_DELAY,
    REG_ROOT_DISP  = `NTP_TS_ADDR_ROOT_DISP,
    REG_REF_ID     = `NTP_TS_ADDR_REF_ID,
    REG_TX_OFS     = `NTP_TS_ADDR_TX_OFS
  } api_reg_e;

  // ------------------------------
  // Header field types
  // ------------------------------
  typedef logic [2:0] ntp_blk_idx_t; // 0..5, one per 64-bit block

  typedef logic [`NTP_TS_TIME_W-1:0] ntp_time_t; // Seconds in upper half

  typedef logic [`NTP_TS_API_DW-1:0] ntp_word_t; // Register and header word

  typedef logic [2:0] ntp_version_t; // VN field

  typedef logic [7:0] ntp_poll_t; // Log2 seconds, signed on the wire

endpackage

/* hw/ntp_ts_cfg.svh */
// Fixed 48-byte NTPv4 header, no extension fields; API addresses are byte-wide, data 32 bits
`ifndef NTP_TS_CFG_SVH
`define NTP_TS_CFG_SVH

// ------------------------------
// API register map
// ------------------------------
`define NTP_TS_ADDR_CONFIG     8'h10 // LI | VN | mode | stratum | poll | precision
`define NTP_TS_ADDR_ROOT_DELAY 8'h11 // Root delay, NTP short format
`define NTP_TS_ADDR_ROOT_DISP  8'h12 // Root dispersion, NTP short format
`define NTP_TS_ADDR_REF_ID     8'h13 // Reference ID as sent
`define NTP_TS_ADDR_TX_OFS     8'h14 // Added to NTP time for the transmit stamp

// Bus widths
`define NTP_TS_API_AW 8
`define NTP_TS_API_DW 32
`define NTP_TS_TIME_W 64 // 32.32 seconds and fraction

// ------------------------------
// Header geometry
// ------------------------------
`define NTP_TS_HDR_BITS 384
`define NTP_TS_BLK_W    64
`define NTP_TS_BLOCKS   6 // HDR_BITS / BLK_W

// Kiss-of-death code, RFC 5905 section 7.4
`define NTP_TS_KOD_REFID 32'h4e54534e // "NTSN"

// Defaults when the config field is zero
`define NTP_TS_DEF_MODE    3'd4 // Server
`define NTP_TS_DEF_STRATUM 8'd1 // Primary reference

`endif
